/* ipgu.f */
rtl/ipguGeomPkg.sv
rtl/ipguCtrlPkg.sv
rtl/memCtrlIf.sv
rtl/scanIf.sv
rtl/pixelRam.sv
rtl/ipguMemory.sv
rtl/ipguAddrCompute.sv
rtl/ipguCtrlUnit.sv
rtl/ipguOutBuffer.sv
rtl/ipgu.sv
bench/ipguTb.sv

/* runSim.sh */
#!/bin/sh
# Build the IPGU testbench with Verilator, run it and check the log

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -Wno-fatal --top-module ipguTb \
    -f ipgu.f -o ipguSim > build.log 2>&1 \
    || { echo "Build failed, see build.log"; exit 1; }

./obj_dir/ipguSim > sim.log 2>&1
grep -qx "Test OK" sim.log && echo "Simulation passed" \
    || { echo "Simulation failed, see sim.log"; exit 1; }

/* bench/ipguTb.sv */
`timescale 1ns/1ns
`default_nettype none

module ipguTb;
    import ipguGeomPkg::*;

    localparam int NUM_TESTS      = 4;
    localparam int WIN_BITS       = WIN_PIXELS * 8;
    localparam int LEVEL0_WINDOWS = (IMG_DIM / WIN_DIM) * (IMG_DIM / WIN_DIM);
    localparam int PAT_RAMP       = 0;
    localparam int PAT_CHECKER    = 1;
    localparam int PAT_RANDOM     = 2;

    // Stimulus table, one row per run: image pattern, HEU stall, window count
    int patternTab [NUM_TESTS] = '{PAT_RAMP, PAT_CHECKER, PAT_RANDOM, PAT_RANDOM};
    int stallTab   [NUM_TESTS] = '{0, 3, 1, 6};
    int windowTab  [NUM_TESTS] = '{5, 5, 5, 5};

    logic                      clk;
    logic                      reset;
    logic                      extCs;
    logic                      extWe;
    logic [RAM1_ADDR_BITS-1:0] extAddr;
    pixelT                     extData;
    logic                      initIpgu;
    logic                      rdyIpgu;
    logic                      rdyHeu;
    logic                      vldIpgu;
    logic                      winLevel;
    logic [WIN_BITS-1:0]       winData;

    // Reference copy of the loaded frame
    pixelT       image [IMG_DIM * IMG_DIM];
    int unsigned randState;
    int          cycleCount;
    int          cycleLimit;
    int          checkCount;
    int          errorCount;

    ipgu ipgu_inst (
        .clk,
        .reset,
        .extCs,
        .extWe,
        .extAddr,
        .extData,
        .initIpgu,
        .rdyIpgu,
        .rdyHeu,
        .vldIpgu,
        .winLevel,
        .winData
    );

    // 20 ns clock
    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    ////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////

    // Classic C library LCG step
    function automatic int unsigned lcgNext(input int unsigned s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    function automatic string patternName(input int pattern);
        case (pattern)
            PAT_RAMP:    return "ramp";
            PAT_CHECKER: return "checker";
            default:     return "random";
        endcase
    endfunction

    // Level 0 block k at (8*(k mod 2), 8*(k div 2)), level 1 is every second pixel
    function automatic logic [WIN_BITS-1:0] expectedWindow(input int level, input int k);
        logic [WIN_BITS-1:0] win;
        int                  i;
        int                  px;
        int                  py;
        win = '0;
        for (i = 0; i < WIN_PIXELS; i++) begin
            if (level == 0) begin
                px = WIN_DIM * (k % 2) + i % WIN_DIM;
                py = WIN_DIM * (k / 2) + i / WIN_DIM;
            end else begin
                px = 2 * (i % WIN_DIM);
                py = 2 * (i / WIN_DIM);
            end
            win[8*i +: 8] = image[py * IMG_DIM + px];
        end
        return win;
    endfunction

    // Load, window reads, both scale passes, stalls and some slack per run
    function automatic int runBudget();
        int total;
        int t;
        total = 16;
        for (t = 0; t < NUM_TESTS; t++) begin
            total += IMG_DIM * IMG_DIM + 4;
            total += windowTab[t] * (66 + 2 + stallTab[t]);
            total += 130 + 64;
        end
        return total;
    endfunction

    // Inputs change 2 ns after the edge, outputs are settled by then
    task automatic nextCycle();
        @(posedge clk);
        #2;
    endtask

    task automatic checkValue(input logic [WIN_BITS-1:0] actual,
                              input logic [WIN_BITS-1:0] expected,
                              input string what);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("Error at %0t ns: %s, got %0h, expected %0h",
                     $time, what, actual, expected);
        end
    endtask

    task automatic fillImage(input int pattern);
        int   a;
        pixelT base;
        for (a = 0; a < IMG_DIM * IMG_DIM; a++) begin
            case (pattern)
                PAT_RAMP: begin
                    image[a] = pixelT'(a);
                end
                PAT_CHECKER: begin
                    // 1x1 checker, xored with the address
                    base     = (((a % IMG_DIM) + (a / IMG_DIM)) % 2 == 1) ? 8'hC3 : 8'h3C;
                    image[a] = base ^ pixelT'(a);
                end
                default: begin
                    randState = lcgNext(randState);
                    image[a]  = randState[23:16];
                end
            endcase
        end
    endtask

    // Pixel by pixel through the external port
    task automatic loadImage();
        int a;
        for (a = 0; a < IMG_DIM * IMG_DIM; a++) begin
            extCs   = 1'b1;
            extWe   = 1'b1;
            extAddr = RAM1_ADDR_BITS'(a);
            extData = image[a];
            nextCycle();
        end
        extCs = 1'b0;
        extWe = 1'b0;
    endtask

    task automatic collectWindow(input int k, input int stall);
        logic [WIN_BITS-1:0] held;
        int                  level;
        int                  s;
        level = (k < LEVEL0_WINDOWS) ? 0 : 1;
        while (!vldIpgu) begin
            nextCycle();
        end
        held = winData;
        checkValue(WIN_BITS'(winLevel), WIN_BITS'(level), $sformatf("window %0d level", k));
        checkValue(winData, expectedWindow(level, k), $sformatf("window %0d pixels", k));
        // HEU back-pressure, offer stays put
        for (s = 0; s < stall; s++) begin
            nextCycle();
            checkValue(WIN_BITS'(vldIpgu), WIN_BITS'(1), $sformatf("window %0d vld held", k));
            checkValue(winData, held, $sformatf("window %0d data held", k));
        end
        // Transfer at the next edge
        rdyHeu = 1'b1;
        nextCycle();
        rdyHeu = 1'b0;
        checkValue(WIN_BITS'(vldIpgu), '0, $sformatf("window %0d vld after transfer", k));
    endtask

    task automatic runTest(input int t);
        int errorsBefore;
        int k;
        errorsBefore = errorCount;
        fillImage(patternTab[t]);
        loadImage();
        checkValue(WIN_BITS'(rdyIpgu), WIN_BITS'(1), "rdyIpgu before start");
        initIpgu = 1'b1;
        nextCycle();
        initIpgu = 1'b0;
        checkValue(WIN_BITS'(rdyIpgu), '0, "rdyIpgu after initIpgu");
        for (k = 0; k < windowTab[t]; k++) begin
            collectWindow(k, stallTab[t]);
        end
        // Back to idle after the last transfer
        while (!rdyIpgu) begin
            nextCycle();
        end
        $display("Run %0d, %s image, stall %0d: %0d windows, %0d errors", t,
                 patternName(patternTab[t]), stallTab[t], windowTab[t],
                 errorCount - errorsBefore);
    endtask

    ////////////////////////////////////////
    // Main flow and watchdog
    ////////////////////////////////////////

    initial begin : mainFlow
        int t;
        reset      = 1'b1;
        extCs      = 1'b0;
        extWe      = 1'b0;
        extAddr    = '0;
        extData    = '0;
        initIpgu   = 1'b0;
        rdyHeu     = 1'b0;
        randState  = 44;
        checkCount = 0;
        errorCount = 0;
        repeat (4) nextCycle();
        reset = 1'b0;
        nextCycle();
        checkValue(WIN_BITS'(vldIpgu), '0, "vldIpgu after reset");
        checkValue(WIN_BITS'(rdyIpgu), WIN_BITS'(1), "rdyIpgu after reset");
        for (t = 0; t < NUM_TESTS; t++) begin
            runTest(t);
        end
        $display("Summary: %0d runs, %0d checks, %0d errors", NUM_TESTS, checkCount, errorCount);
        if (errorCount == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

    initial begin : watchdog
        cycleCount = 0;
        cycleLimit = runBudget();
        while (cycleCount < cycleLimit) begin
            @(posedge clk);
            cycleCount++;
        end
        $display("Timeout: the DUT did not finish within %0d clock cycles", cycleLimit);
        $display("Test FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* rtl/ipgu.sv */
`timescale 1ns/1ns
`default_nettype none

module ipgu (
    input  logic                                             clk,
    input  logic                                             reset,
    // External load port
    input  logic                                             extCs,
    input  logic                                             extWe,
    input  logic [ipguGeomPkg::RAM1_ADDR_BITS-1:0]           extAddr,
    input  ipguGeomPkg::pixelT                               extData,
    // Host handshake
    input  logic                                             initIpgu,
    output logic                                             rdyIpgu,
    // HEU side
    input  logic                                             rdyHeu,
    output logic                                             vldIpgu,
    output logic                                             winLevel,
    output ipguGeomPkg::pixelT [ipguGeomPkg::WIN_PIXELS-1:0] winData
);

    logic capture;

    memCtrlIf memBus ();
    scanIf    scanBus ();

    ////////////////////////////////////////
    // Blocks
    ////////////////////////////////////////

    ipguMemory memory (
        .clk,
        .extCs,
        .extWe,
        .extAddr,
        .extData,
        .mem     (memBus)
    );

    ipguAddrCompute addrCompute (
        .clk,
        .reset,
        .scan    (scanBus),
        .mem     (memBus)
    );

    ipguCtrlUnit ctrlUnit (
        .clk,
        .reset,
        .initIpgu,
        .extCs,
        .rdyHeu,
        .rdyIpgu,
        .vldIpgu,
        .winLevel,
        .capture,
        .scan    (scanBus),
        .mem     (memBus)
    );

    // Window buffer, filled from frame RAM reads
    ipguOutBuffer outBuffer (
        .clk,
        .reset,
        .capture,
        .pixel   (memBus.rdPixel),
        .window  (winData)
    );

endmodule

`default_nettype wire

/* rtl/ipguOutBuffer.sv */
`timescale 1ns/1ns
`default_nettype none

module ipguOutBuffer (
    input  logic                                           clk,
    input  logic                                           reset,
    input  logic                                           capture,
    input  ipguGeomPkg::pixelT                             pixel,
    output ipguGeomPkg::pixelT [ipguGeomPkg::WIN_PIXELS-1:0] window
);
    import ipguGeomPkg::*;

    logic [$clog2(WIN_PIXELS)-1:0] slotIdx;

    // Slot counter, wraps after a full window
    always_ff @(posedge clk) begin
        if (reset) begin
            slotIdx <= '0;
        end else if (capture) begin
            slotIdx <= slotIdx + 1'b1;
        end
    end

    // Raster pixel i lands in byte i
    always_ff @(posedge clk) begin
        if (capture) begin
            window[slotIdx] <= pixel;
        end
    end

endmodule

`default_nettype wire

/* rtl/ipguCtrlUnit.sv */
`timescale 1ns/1ns
`default_nettype none

module ipguCtrlUnit (
    input  logic      clk,
    input  logic      reset,
    input  logic      initIpgu,
    input  logic      extCs,
    input  logic      rdyHeu,
    output logic      rdyIpgu,
    output logic      vldIpgu,
    output logic      winLevel,
    output logic      capture,
    scanIf.ctrl       scan,
    memCtrlIf.engine  mem
);
    import ipguGeomPkg::*;
    import ipguCtrlPkg::*;

    ctrlStateT state;
    ctrlStateT stateNext;
    logic      level;
    logic      scanDone;
    logic      stepQ;
    logic      scaling;
    logic      topLevel;

    assign scaling  = (state == SCALE_DOWN) || (state == COPY_BACK);
    assign topLevel = (level == 1'(NUM_LEVELS - 1));

    ////////////////////////////////////////
    // Next state
    ////////////////////////////////////////

    always_comb begin
        stateNext      = state;
        scan.scanStart = 1'b0;
        case (state)
            IDLE: begin
                // Start only when the loader is off the frame RAM
                if (initIpgu && !extCs) begin
                    stateNext      = WIN_READ;
                    scan.scanStart = 1'b1;
                end
            end
            WIN_READ: begin
                if (scan.lastPixel) begin
                    stateNext = WIN_DRAIN;
                end
            end
            WIN_DRAIN: begin
                stateNext = HEU_WAIT;
            end
            HEU_WAIT: begin
                if (rdyHeu) begin
                    if (!scan.lastWindow) begin
                        stateNext      = WIN_READ;
                        scan.scanStart = 1'b1;
                    end else if (!topLevel) begin
                        stateNext      = SCALE_DOWN;
                        scan.scanStart = 1'b1;
                    end else begin
                        stateNext = DONE;
                    end
                end
            end
            SCALE_DOWN: begin
                if (scanDone) begin
                    stateNext      = COPY_BACK;
                    scan.scanStart = 1'b1;
                end
            end
            COPY_BACK: begin
                // Scaled image back in the frame for the level 1 read
                if (scanDone) begin
                    stateNext      = WIN_READ;
                    scan.scanStart = 1'b1;
                end
            end
            DONE: begin
                stateNext = IDLE;
            end
            default: begin
                stateNext = IDLE;
            end
        endcase
    end

    ////////////////////////////////////////
    // Scan and RAM enables
    ////////////////////////////////////////

    // Scale scans stop stepping for the trailing write
    assign scan.scanStep = (state == WIN_READ) || (scaling && !scanDone);
    assign scan.scanMode = (state == SCALE_DOWN) ? DECIMATE :
                           (state == COPY_BACK)  ? COPY     : WINDOW;

    assign mem.ram1Cs = (scan.scanStep && ((state == WIN_READ) || (state == SCALE_DOWN)))
                     || (stepQ && (state == COPY_BACK));
    assign mem.ram1We = stepQ && (state == COPY_BACK);
    assign mem.ram2Cs = (stepQ && (state == SCALE_DOWN))
                     || (scan.scanStep && (state == COPY_BACK));
    assign mem.ram2We = stepQ && (state == SCALE_DOWN);

    // Status to the host and the HEU
    assign rdyIpgu  = (state == IDLE);
    assign vldIpgu  = (state == HEU_WAIT);
    assign winLevel = level;

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= IDLE;
            level    <= 1'b0;
            scanDone <= 1'b0;
            stepQ    <= 1'b0;
            capture  <= 1'b0;
        end else begin
            state   <= stateNext;
            stepQ   <= scan.scanStep;
            // Pixel arrives one cycle after its read
            capture <= (state == WIN_READ);
            if (scan.scanStart) begin
                scanDone <= 1'b0;
            end else if (scaling && scan.scanStep && scan.lastPixel) begin
                scanDone <= 1'b1;
            end
            if ((state == COPY_BACK) && scanDone) begin
                level <= 1'b1;
            end else if (state == DONE) begin
                level <= 1'b0;
            end
        end
    end

    // Window offer holds until the HEU takes it
    vldHeldAssert: assert property (@(posedge clk) disable iff (reset)
        vldIpgu && !rdyHeu |=> vldIpgu)
        else $error("vldIpgu dropped before rdyHeu");

endmodule

`default_nettype wire

/* rtl/ipguAddrCompute.sv */
`timescale 1ns/1ns
`default_nettype none

module ipguAddrCompute (
    input  logic      clk,
    input  logic      reset,
    scanIf.addr       scan,
    memCtrlIf.engine  mem
);
    import ipguGeomPkg::*;
    import ipguCtrlPkg::*;

    logic [IMG_BITS-1:0]    originX;
    logic [IMG_BITS-1:0]    originY;
    logic [IMG_BITS:0]      levelDim;
    logic [SCALED_BITS-1:0] x;
    logic [SCALED_BITS-1:0] y;
    logic [SCALED_BITS-1:0] xD;
    logic [SCALED_BITS-1:0] yD;
    logic [IMG_BITS:0]      rdX;
    logic [IMG_BITS:0]      rdY;
    logic [IMG_BITS:0]      nextOriginX;
    logic [IMG_BITS:0]      nextOriginY;
    logic                   atLastWindow;
    logic                   windowEnd;
    logic                   lastWindowQ;

    // Window and scale scans both span the full 3-bit counter range
    assign scan.lastPixel = (&x) && (&y);
    assign windowEnd      = scan.scanStep && scan.lastPixel && (scan.scanMode == WINDOW);

    // Origin of the following window
    assign nextOriginX  = {1'b0, originX} + (IMG_BITS + 1)'(WIN_DIM);
    assign nextOriginY  = {1'b0, originY} + (IMG_BITS + 1)'(WIN_DIM);
    assign atLastWindow = (nextOriginX == levelDim) && (nextOriginY == levelDim);

    assign scan.lastWindow = lastWindowQ;

    ////////////////////////////////////////
    // Read coordinates per mode
    ////////////////////////////////////////

    always_comb begin
        case (scan.scanMode)
            DECIMATE: begin
                // Every second pixel of every second row
                rdX = {1'b0, x, 1'b0};
                rdY = {1'b0, y, 1'b0};
            end
            COPY: begin
                rdX = {2'b00, x};
                rdY = {2'b00, y};
            end
            default: begin
                rdX = {1'b0, originX} + {2'b00, x};
                rdY = {1'b0, originY} + {2'b00, y};
            end
        endcase
    end

    // Writes trail reads by one cycle and use the delayed coordinates
    assign mem.ram1Addr = (scan.scanMode == COPY) ? {1'b0, yD, 1'b0, xD}
                                                  : {rdY[IMG_BITS-1:0], rdX[IMG_BITS-1:0]};
    assign mem.ram2Addr = (scan.scanMode == COPY) ? {y, x} : {yD, xD};

    ////////////////////////////////////////
    // Counters
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            x <= '0;
            y <= '0;
        end else if (scan.scanStart) begin
            x <= '0;
            y <= '0;
        end else if (scan.scanStep) begin
            x <= x + 1'b1;
            // Next row when the column wraps
            if (&x) begin
                y <= y + 1'b1;
            end
        end
    end

    // Registered read address
    always_ff @(posedge clk) begin
        if (scan.scanStep) begin
            xD <= x;
            yD <= y;
        end
    end

    // Window origin and level size
    always_ff @(posedge clk) begin
        if (reset) begin
            originX     <= '0;
            originY     <= '0;
            levelDim    <= (IMG_BITS + 1)'(IMG_DIM);
            lastWindowQ <= 1'b0;
        end else begin
            if (scan.scanStart) begin
                lastWindowQ <= 1'b0;
            end else if (windowEnd) begin
                lastWindowQ <= atLastWindow;
            end
            if (windowEnd) begin
                if (atLastWindow) begin
                    // Full size again for the next run once the level ends
                    originX  <= '0;
                    originY  <= '0;
                    levelDim <= (IMG_BITS + 1)'(IMG_DIM);
                end else if (nextOriginX == levelDim) begin
                    originX <= '0;
                    originY <= nextOriginY[IMG_BITS-1:0];
                end else begin
                    originX <= nextOriginX[IMG_BITS-1:0];
                end
            end else if (scan.scanStep && scan.lastPixel && (scan.scanMode == COPY)) begin
                levelDim <= (IMG_BITS + 1)'(SCALED_DIM);
            end
        end
    end

    // Stepped reads stay inside the current level
    coordRangeAssert: assert property (@(posedge clk) disable iff (reset)
        scan.scanStep |-> (rdX < levelDim) && (rdY < levelDim))
        else $error("Scan coordinate outside the current level");

endmodule

`default_nettype wire

/* rtl/ipguMemory.sv */
`timescale 1ns/1ns
`default_nettype none

module ipguMemory (
    input  logic                                   clk,
    input  logic                                   extCs,
    input  logic                                   extWe,
    input  logic [ipguGeomPkg::RAM1_ADDR_BITS-1:0] extAddr,
    input  ipguGeomPkg::pixelT                     extData,
    memCtrlIf.memory                               mem
);
    import ipguGeomPkg::*;

    logic                      ram1Cs;
    logic                      ram1We;
    logic [RAM1_ADDR_BITS-1:0] ram1Addr;
    pixelT                     ram1WrData;
    pixelT                     ram1RdData;
    pixelT                     ram2RdData;

    ////////////////////////////////////////
    // Frame RAM port arbitration
    ////////////////////////////////////////

    // External loader wins whenever it selects
    assign ram1Cs     = extCs | mem.ram1Cs;
    assign ram1We     = extCs ? extWe   : mem.ram1We;
    assign ram1Addr   = extCs ? extAddr : mem.ram1Addr;
    // Copy-back path, scaled pixels return to the frame
    assign ram1WrData = extCs ? extData : ram2RdData;

    assign mem.rdPixel = ram1RdData;

    ////////////////////////////////////////
    // RAMs
    ////////////////////////////////////////

    pixelRam #(.ADDR_BITS(RAM1_ADDR_BITS)) ram1 (
        .clk,
        .cs     (ram1Cs),
        .we     (ram1We),
        .addr   (ram1Addr),
        .wrData (ram1WrData),
        .rdData (ram1RdData)
    );

    // Decimation path, frame pixels go straight in
    pixelRam #(.ADDR_BITS(RAM2_ADDR_BITS)) ram2 (
        .clk,
        .cs     (mem.ram2Cs),
        .we     (mem.ram2We),
        .addr   (mem.ram2Addr),
        .wrData (ram1RdData),
        .rdData (ram2RdData)
    );

    // Loader and engine never share the frame RAM
    extExclusiveAssert: assert property (@(posedge clk) !(extCs && mem.ram1Cs))
        else $error("External and internal frame RAM access in the same cycle");

endmodule

`default_nettype wire

/* rtl/pixelRam.sv */
`timescale 1ns/1ns
`default_nettype none

module pixelRam #(
    parameter int ADDR_BITS = 8
) (
    input  logic                  clk,
    input  logic                  cs,
    input  logic                  we,
    input  logic [ADDR_BITS-1:0]  addr,
    input  ipguGeomPkg::pixelT    wrData,
    output ipguGeomPkg::pixelT    rdData
);
    import ipguGeomPkg::*;

    pixelT memArray [2**ADDR_BITS];

    // One port, write or registered read per cycle
    always_ff @(posedge clk) begin
        if (cs) begin
            if (we) begin
                memArray[addr] <= wrData;
            end else begin
                // Data shows up the cycle after the address
                rdData <= memArray[addr];
            end
        end
    end

endmodule

`default_nettype wire

/* rtl/scanIf.sv */
`timescale 1ns/1ns
`default_nettype none

interface scanIf;
    import ipguCtrlPkg::*;

    // Scan control from the FSM
    logic     scanStart;
    logic     scanStep;
    scanModeT scanMode;

    // Scan status back from the address unit
    logic     lastPixel;
    logic     lastWindow;

    modport ctrl (
        output scanStart, scanStep, scanMode,
        input  lastPixel, lastWindow
    );

    modport addr (
        input  scanStart, scanStep, scanMode,
        output lastPixel, lastWindow
    );

endinterface

`default_nettype wire

/* rtl/memCtrlIf.sv */
`timescale 1ns/1ns
`default_nettype none

interface memCtrlIf;
    import ipguGeomPkg::*;

    // Internal RAM enables, from the control unit
    logic ram1Cs;
    logic ram1We;
    logic ram2Cs;
    logic ram2We;

    // Addresses, from the address unit
    logic [RAM1_ADDR_BITS-1:0] ram1Addr;
    logic [RAM2_ADDR_BITS-1:0] ram2Addr;

    // Frame RAM read data, feeds the output buffer
    pixelT rdPixel;

    modport engine (
        output ram1Cs, ram1We, ram2Cs, ram2We,
        output ram1Addr, ram2Addr,
        input  rdPixel
    );

    modport memory (
        input  ram1Cs, ram1We, ram2Cs, ram2We,
        input  ram1Addr, ram2Addr,
        output rdPixel
    );

endinterface

`default_nettype wire

/* rtl/ipguCtrlPkg.sv */
`default_nettype none

package ipguCtrlPkg;

    // Sequencer states
    typedef enum logic [2:0] {
        IDLE,
        WIN_READ,
        WIN_DRAIN,
        HEU_WAIT,
        SCALE_DOWN,
        COPY_BACK,
        DONE
    } ctrlStateT;

    // Address pattern for the current scan
    typedef enum logic [1:0] {
        WINDOW,
        DECIMATE,
        COPY
    } scanModeT;

endpackage

`default_nettype wire

/* rtl/ipguGeomPkg.sv */
`default_nettype none

package ipguGeomPkg;

    // Full frame, 16x16 greyscale
    localparam int IMG_BITS = 4;
    localparam int IMG_DIM  = 1 << IMG_BITS;

    // Detector window handed to the HEU
    localparam int WIN_DIM    = 8;
    localparam int WIN_PIXELS = WIN_DIM * WIN_DIM;

    // Level 1 image after decimation by two
    localparam int SCALED_DIM  = IMG_DIM / 2;
    localparam int SCALED_BITS = IMG_BITS - 1;
    localparam int NUM_LEVELS  = 2;

    // Frame RAM holds the full image, scale RAM the half-size one
    localparam int RAM1_ADDR_BITS = 2 * IMG_BITS;
    localparam int RAM2_ADDR_BITS = 2 * SCALED_BITS;

    typedef logic [7:0] pixelT;

endpackage

`default_nettype wire
